//--- cpu900_pkg.sv
// shared constants for the banked register file core
// register code union with its two views
// write port struct, step size, write size and alu op types
package cpu900_pkg;

    localparam logic [3:0] CUR_BANK  = 4'he; // bank selected by rfp
    localparam logic [3:0] PREV_BANK = 4'hd; // bank rfp-1
    localparam logic [3:0] ZERO_PAGE = 4'h4; // reads as zero on the source port

    localparam int N_ACC = 64; // general register bytes, 16 per bank
    localparam int N_PTR = 16; // XIX, XIY, XIZ, XSP

    localparam logic [7:0] DUMP_PTR_BASE = 8'h40;
    localparam logic [7:0] DUMP_SR_BASE  = 8'h50;

    typedef struct packed {
        logic       kind;  // 0 here
        logic       spare;
        logic [1:0] bank;
        logic [3:0] idx;   // byte within the bank
    } acc_code_t;

    typedef struct packed {
        logic       kind;  // 1 here
        logic [2:0] spare;
        logic [3:0] idx;   // byte within the pointer block
    } ptr_code_t;

    typedef union packed {
        acc_code_t acc;
        ptr_code_t ptr;
    } reg_code_u;

    typedef enum logic [2:0] {
        SZ_NONE = 3'b000,
        SZ_BYTE = 3'b001,
        SZ_WORD = 3'b010,
        SZ_LONG = 3'b100
    } wr_size_t;

    typedef struct packed {
        reg_code_u   code;
        wr_size_t    size;
        logic        flag_only; // flags only, no register write
        logic [31:0] data;
    } wr_port_t;

    typedef enum logic [1:0] {STEP_1 = 2'd0, STEP_2 = 2'd1, STEP_4 = 2'd2} step_t;

    typedef enum logic [2:0] {ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_t;

endpackage

//--- reg_code_dec.sv
// register code decoder
// resolves current and previous bank codes against rfp
// and picks the indexed codes for memory addressing
`timescale 1ns/100ps

module reg_code_dec
    import cpu900_pkg::*;
(
    input  logic [1:0] rfp,
    input  logic [7:0] src,
    input  logic [7:0] dst,
    input  logic [7:0] idx_sel,
    input  logic [7:0] idx_aux,
    input  logic       idx_en,
    output reg_code_u  rd0_code,
    output reg_code_u  aux_code,
    output reg_code_u  rd1_code
);

    function automatic reg_code_u map_code(logic [1:0] bank_ptr, logic [7:0] raw);
        reg_code_u c;
        c = raw;
        if (raw[7:4] == CUR_BANK) begin
            c.acc.kind  = 1'b0;
            c.acc.spare = 1'b0;
            c.acc.bank  = bank_ptr;
        end else if (raw[7:4] == PREV_BANK) begin
            c.acc.kind  = 1'b0;
            c.acc.spare = 1'b0;
            c.acc.bank  = bank_ptr - 2'd1; // wraps from bank 0 to bank 3
        end
        return c;
    endfunction

    assign rd0_code = map_code(rfp, idx_en ? idx_sel : src);
    assign rd1_code = map_code(rfp, idx_en ? idx_aux : dst);

    // second pointer of a two-pointer transfer, bit 2 cleared
    assign aux_code = map_code(rfp, idx_sel & 8'hfb);

endmodule

//--- reg_bank.sv
// banked register storage
// three combinational read ports, sized little-endian write
// index steps, BC/XDE/XIX countdown, stack pointer moves
// register file pointer
`timescale 1ns/100ps

module reg_bank
    import cpu900_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  reg_code_u              rd0_code,
    input  reg_code_u              aux_code,
    input  reg_code_u              rd1_code,
    input  wr_port_t               wr,
    input  step_t                  step,
    input  logic                   reg_inc,
    input  logic                   reg_dec,
    input  logic                   dec_bc,
    input  logic                   dec_xde,
    input  logic                   dec_xix,
    input  logic [2:0]             inc_xsp,
    input  logic [2:0]             dec_xsp,
    input  logic                   inc_rfp,
    input  logic                   dec_rfp,
    input  logic                   rfp_we,
    input  logic [1:0]             imm,
    output logic [1:0]             rfp,
    output logic [31:0]            src_out,
    output logic [31:0]            aux_out,
    output logic [31:0]            dst_out,
    output logic [31:0]            xsp,
    output logic                   bc_unity,
    output logic [N_ACC-1:0][7:0]  acc_bytes,
    output logic [N_PTR-1:0][7:0]  ptr_bytes
);

    // general bytes at 0..63, pointer bytes right above them
    logic [N_ACC+N_PTR-1:0][7:0] regs;

    logic [6:0]  rd0_a;
    logic [6:0]  aux_a;
    logic [6:0]  rd1_a;
    logic [6:0]  wr_a;
    logic [6:0]  bc_a;
    logic [6:0]  xde_a;
    logic [31:0] step_amt;
    logic [31:0] rd0_val;
    logic [31:0] cur_xde;
    logic [31:0] xix;
    logic [15:0] cur_bc;

    function automatic logic [6:0] addr_of(reg_code_u c);
        if (c.ptr.kind)
            return 7'(N_ACC) + {3'd0, c.ptr.idx};
        return {1'b0, c.acc.bank, c.acc.idx};
    endfunction

    // upper bytes come from the aligned long, low byte from the code itself
    function automatic logic [31:0] rd_reg(logic [6:0] a);
        return {regs[{a[6:2], 2'd3}], regs[{a[6:2], 2'd2}],
                regs[{a[6:1], 1'b1}], regs[a]};
    endfunction

    assign rd0_a = addr_of(rd0_code);
    assign aux_a = addr_of(aux_code);
    assign rd1_a = addr_of(rd1_code);
    assign wr_a  = addr_of(wr.code);
    assign bc_a  = {1'b0, rfp, 4'h4};
    assign xde_a = {1'b0, rfp, 4'h8};

    always_comb begin
        case (step)
            STEP_2:  step_amt = 32'd2;
            STEP_4:  step_amt = 32'd4;
            default: step_amt = 32'd1;
        endcase
    end

    assign rd0_val = rd_reg(rd0_a);
    assign cur_bc  = regs[bc_a +: 2];
    assign cur_xde = regs[xde_a +: 4];
    assign xix     = regs[N_ACC +: 4];
    assign xsp     = regs[N_ACC+12 +: 4];

    assign src_out = (rd0_code[7:4] == ZERO_PAGE) ? 32'd0 : rd0_val;
    assign aux_out = rd_reg(aux_a);
    assign dst_out = rd_reg(rd1_a) - (reg_dec ? step_amt : 32'd0); // pre-decremented view

    assign acc_bytes = regs[N_ACC-1:0];
    assign ptr_bytes = regs[N_ACC+N_PTR-1:N_ACC];

    // later assignments win: steps, countdowns, stack, then the write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs     <= '0;
            bc_unity <= 1'b0;
        end else if (cen) begin
            bc_unity <= cur_bc == 16'd1;
            if (reg_inc)
                regs[{rd0_a[6:2], 2'd0} +: 4] <= rd0_val + step_amt;
            if (reg_dec)
                regs[{rd0_a[6:2], 2'd0} +: 4] <= rd0_val - step_amt;
            if (dec_bc)
                regs[bc_a +: 2] <= cur_bc - 16'd1;
            if (dec_xde)
                regs[xde_a +: 4] <= cur_xde - step_amt; // LDD style block moves
            if (dec_xix)
                regs[N_ACC +: 4] <= xix - step_amt;
            if (dec_xsp != 3'd0)
                regs[N_ACC+12 +: 4] <= xsp - 32'(dec_xsp);
            if (inc_xsp != 3'd0)
                regs[N_ACC+12 +: 4] <= xsp + 32'(inc_xsp);
            if (!wr.flag_only) begin
                if (wr.size[0])
                    regs[wr_a] <= wr.data[7:0];
                if (wr.size[1])
                    regs[{wr_a[6:1], 1'b0} +: 2] <= wr.data[15:0];
                if (wr.size[2])
                    regs[{wr_a[6:2], 2'd0} +: 4] <= wr.data;
            end
        end
    end

    // rfp: load over decrement over increment
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else if (cen) begin
            if (rfp_we)
                rfp <= imm;
            else if (dec_rfp)
                rfp <= rfp - 2'd1;
            else if (inc_rfp)
                rfp <= rfp + 2'd1;
        end
    end

endmodule

//--- alu_flags.sv
// sized alu for the write-back path
// sign, zero and carry flags latched into the status register
`timescale 1ns/100ps

module alu_flags
    import cpu900_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  alu_op_t     op,
    input  wr_size_t    size,
    input  logic        data_sel,
    input  logic [31:0] a,       // destination operand
    input  logic [31:0] b,       // source operand
    output logic [31:0] alu_dout,
    output logic [15:0] sr
);

    logic [31:0] mask;
    logic [31:0] am;
    logic [31:0] bm;
    logic [32:0] wide;
    logic [31:0] res;
    logic        sign_bit;
    logic        zero_bit;
    logic        carry_bit;

    always_comb begin
        if (size[0])
            mask = 32'h0000_00ff;
        else if (size[1])
            mask = 32'h0000_ffff;
        else
            mask = 32'hffff_ffff; // long, also when no size is given
        am = a & mask;
        bm = b & mask;
        case (op)
            ALU_ADD: wide = {1'b0, am} + {1'b0, bm};
            ALU_SUB: wide = {1'b0, am} - {1'b0, bm}; // borrow shows above the width
            ALU_AND: wide = {1'b0, am & bm};
            ALU_OR:  wide = {1'b0, am | bm};
            ALU_XOR: wide = {1'b0, am ^ bm};
            default: wide = {1'b0, bm};              // pass source through
        endcase
        res      = wide[31:0] & mask;
        zero_bit = res == 32'd0;
        if (size[0]) begin
            sign_bit  = res[7];
            carry_bit = wide[8];
        end else if (size[1]) begin
            sign_bit  = res[15];
            carry_bit = wide[16];
        end else begin
            sign_bit  = res[31];
            carry_bit = wide[32];
        end
    end

    assign alu_dout = res;

    // high byte keeps the op for debug, low byte is S Z . . . . . C
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sr <= 16'd0;
        else if (cen && op != ALU_PASS && !data_sel)
            sr <= {5'd0, op, sign_bit, zero_bit, 5'd0, carry_bit};
    end

endmodule

//--- reg_dump.sv
// debug readout, one byte per address
// general bytes, pointer bytes and both status bytes
`timescale 1ns/100ps

module reg_dump
    import cpu900_pkg::*;
(
    input  logic                  clk,
    input  logic [7:0]            dmp_addr,
    input  logic [N_ACC-1:0][7:0] acc_bytes,
    input  logic [N_PTR-1:0][7:0] ptr_bytes,
    input  logic [15:0]           sr,
    output logic [7:0]            dmp_din
);

    // free running, not gated by cen
    always_ff @(posedge clk) begin
        if (dmp_addr < DUMP_PTR_BASE)
            dmp_din <= acc_bytes[dmp_addr[5:0]];
        else if (dmp_addr < DUMP_PTR_BASE + 8'(N_PTR))
            dmp_din <= ptr_bytes[dmp_addr[3:0]]; // base is 16-aligned
        else if (dmp_addr == DUMP_SR_BASE)
            dmp_din <= sr[15:8];
        else if (dmp_addr == DUMP_SR_BASE + 8'd1)
            dmp_din <= sr[7:0];
        else
            dmp_din <= 8'd0;
    end

endmodule

//--- regs_top.sv
// register file top level
// code decoder, register bank, alu with status and dump port
// write data picks ram or alu result
`timescale 1ns/100ps

module regs_top
    import cpu900_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        inc_rfp,
    input  logic        dec_rfp,
    input  logic        rfp_we,
    input  logic [1:0]  imm,
    input  logic        dec_bc,
    input  logic [2:0]  inc_xsp,
    input  logic [2:0]  dec_xsp,
    input  step_t       step,
    input  logic        reg_inc,
    input  logic        reg_dec,
    input  logic        dec_xde,
    input  logic        dec_xix,
    input  logic [7:0]  src,
    input  logic [7:0]  dst,
    input  logic [7:0]  idx_sel,
    input  logic [7:0]  idx_aux,
    input  logic        idx_en,
    input  alu_op_t     alu_op,
    input  wr_size_t    size,
    input  logic        data_sel,   // 1 for ram data
    input  logic [31:0] ram_dout,
    input  logic        flag_only,
    input  logic [7:0]  dmp_addr,
    output logic [31:0] src_out,
    output logic [31:0] aux_out,
    output logic [31:0] dst_out,
    output logic [31:0] xsp,
    output logic [1:0]  rfp,
    output logic        bc_unity,
    output logic [15:0] sr,
    output logic [7:0]  dmp_din
);

    reg_code_u             rd0_code;
    reg_code_u             aux_code;
    reg_code_u             rd1_code;
    wr_port_t              wr;
    logic [31:0]           alu_dout;
    logic [N_ACC-1:0][7:0] acc_bytes;
    logic [N_PTR-1:0][7:0] ptr_bytes;

    assign wr = '{code: rd1_code, size: size, flag_only: flag_only,
                  data: data_sel ? ram_dout : alu_dout};

    reg_code_dec u_dec (
        .rfp, .src, .dst, .idx_sel, .idx_aux, .idx_en,
        .rd0_code, .aux_code, .rd1_code
    );

    reg_bank u_bank (
        .clk, .rst, .cen, .rd0_code, .aux_code, .rd1_code, .wr, .step,
        .reg_inc, .reg_dec, .dec_bc, .dec_xde, .dec_xix, .inc_xsp, .dec_xsp,
        .inc_rfp, .dec_rfp, .rfp_we, .imm, .rfp, .src_out, .aux_out, .dst_out,
        .xsp, .bc_unity, .acc_bytes, .ptr_bytes
    );

    // dst op src
    alu_flags u_alu (
        .clk, .rst, .cen, .op(alu_op), .size, .data_sel,
        .a(dst_out), .b(src_out), .alu_dout, .sr
    );

    reg_dump u_dump (
        .clk, .dmp_addr, .acc_bytes, .ptr_bytes, .sr, .dmp_din
    );

endmodule

//--- regs_properties.sv
// concurrent checks for the register file top level
// bound into regs_top, any failure raises failed
`timescale 1ns/100ps

module regs_properties
    import cpu900_pkg::*;
(
    input logic        clk, rst, cen, inc_rfp, dec_rfp, rfp_we, dec_bc, dec_xde, dec_xix,
    input logic        reg_inc, reg_dec, idx_en, data_sel, flag_only, bc_unity,
    input logic [1:0]  imm, rfp,
    input logic [2:0]  inc_xsp, dec_xsp,
    input step_t       step,
    input logic [7:0]  src, dst, idx_sel, dmp_addr, dmp_din,
    input alu_op_t     alu_op,
    input wr_size_t    size,
    input logic [31:0] ram_dout, src_out, aux_out, dst_out, xsp, alu_dout,
    input logic [15:0] sr
);

    logic        failed = 1'b0; // watched by the testbench
    logic        idle;          // no strobe at all
    logic [31:0] m;
    logic [31:0] wr_exp;
    logic [31:0] step_exp;
    logic [31:0] xsp_exp;
    logic [1:0]  rfp_exp;
    logic [7:0]  dump_exp;
    logic [32:0] alu_exp;       // carry on top
    logic [15:0] sr_exp;

    function automatic logic [31:0] size_mask(wr_size_t sz);
        return sz == SZ_BYTE ? 32'hff : sz == SZ_WORD ? 32'hffff : 32'hffff_ffff;
    endfunction

    function automatic logic [32:0] alu_ref(alu_op_t op, logic [31:0] mk, logic [31:0] a,
                                            logic [31:0] b);
        logic [32:0] sum;
        sum = {1'b0, a & mk} + {1'b0, b & mk};
        case (op)
            ALU_ADD: return {|(sum & ~{1'b0, mk}), sum[31:0] & mk};
            ALU_SUB: return {(a & mk) < (b & mk), ((a & mk) - (b & mk)) & mk}; // borrow
            ALU_AND: return {1'b0, a & b & mk};
            ALU_OR:  return {1'b0, (a | b) & mk};
            ALU_XOR: return {1'b0, (a ^ b) & mk};
            default: return {1'b0, b & mk};
        endcase
    endfunction

    // s is the long that holds the addressed byte
    function automatic logic [7:0] dump_ref(logic [7:0] a, logic [31:0] s, logic [15:0] r);
        if (a < DUMP_SR_BASE)
            return s[8*a[1:0] +: 8];
        if (a == DUMP_SR_BASE)
            return r[15:8];
        return a == DUMP_SR_BASE + 8'd1 ? r[7:0] : 8'd0;
    endfunction

    assign idle = !reg_inc && !reg_dec && !dec_bc && !dec_xde && !dec_xix && inc_xsp == 3'd0
                  && dec_xsp == 3'd0 && !rfp_we && !inc_rfp && !dec_rfp && !idx_en;
    assign m        = size_mask(size);
    assign wr_exp   = (flag_only || size == SZ_NONE) ? dst_out : (dst_out & ~m) | (ram_dout & m);
    assign step_exp = reg_inc ? src_out + (step == STEP_2 ? 32'd2 : step == STEP_4 ? 32'd4 : 32'd1)
                              : src_out - (step == STEP_2 ? 32'd2 : step == STEP_4 ? 32'd4 : 32'd1);
    assign xsp_exp  = inc_xsp != 3'd0 ? xsp + 32'(inc_xsp) : xsp - 32'(dec_xsp);
    assign rfp_exp  = !cen ? rfp : rfp_we ? imm : dec_rfp ? rfp - 2'd1 : inc_rfp ? rfp + 2'd1 : rfp;
    assign dump_exp = dump_ref(dmp_addr, src_out, sr);
    assign alu_exp  = alu_ref(alu_op, m, dst_out, src_out);
    assign sr_exp   = {5'd0, alu_op, |(alu_exp[31:0] & m & ~(m >> 1)), alu_exp[31:0] == 32'd0,
                       5'd0, alu_exp[32]};

    a_write: assert property (@(posedge clk) disable iff (rst)
        cen && idle && data_sel && dst[7:4] != ZERO_PAGE && dst[1:0] == 2'd0
        |=> src != $past(dst) || src_out == $past(wr_exp))
        else begin
            $error("FAILED write expected %h actual %h", $past(wr_exp), src_out);
            failed = 1'b1;
        end

    // aux port reads idx_sel with bit 2 cleared
    a_aux: assert property (@(posedge clk) disable iff (rst)
        cen && idle && data_sel && dst[7:4] != ZERO_PAGE && dst[1:0] == 2'd0
        |=> (idx_sel & 8'hfb) != $past(dst) || aux_out == $past(wr_exp))
        else begin
            $error("FAILED aux_read expected %h actual %h", $past(wr_exp), aux_out);
            failed = 1'b1;
        end

    // explicit bank code on dst against the mapped one on src
    a_bank: assert property (@(posedge clk) disable iff (rst)
        !idx_en && !reg_dec && ((src[7:4] == CUR_BANK && dst == {2'b00, rfp, src[3:0]}) ||
        (src[7:4] == PREV_BANK && dst == {2'b00, rfp - 2'd1, src[3:0]}))
        |-> src_out == dst_out)
        else begin
            $error("FAILED bank_map expected %h actual %h", dst_out, src_out);
            failed = 1'b1;
        end

    a_zero: assert property (@(posedge clk) disable iff (rst)
        !idx_en && src[7:4] == ZERO_PAGE |-> src_out == 32'd0)
        else begin
            $error("FAILED zero_page expected %h actual %h", 32'd0, src_out);
            failed = 1'b1;
        end

    a_rfp: assert property (@(posedge clk) disable iff (rst) 1'b1 |=> rfp == $past(rfp_exp))
        else begin
            $error("FAILED rfp expected %h actual %h", $past(rfp_exp), rfp);
            failed = 1'b1;
        end

    a_step: assert property (@(posedge clk) disable iff (rst)
        cen && (reg_inc ^ reg_dec) && !dec_bc && !dec_xde && !dec_xix && inc_xsp == 3'd0
        && dec_xsp == 3'd0 && !idx_en && size == SZ_NONE && src[1:0] == 2'd0
        && src[7:4] != ZERO_PAGE
        |=> src != $past(src) || rfp != $past(rfp) || src_out == $past(step_exp))
        else begin
            $error("FAILED step expected %h actual %h", $past(step_exp), src_out);
            failed = 1'b1;
        end

    a_xsp: assert property (@(posedge clk) disable iff (rst)
        cen && (inc_xsp != 3'd0 || dec_xsp != 3'd0) && !reg_inc && !reg_dec
        && (size == SZ_NONE || flag_only) |=> xsp == $past(xsp_exp))
        else begin
            $error("FAILED xsp expected %h actual %h", $past(xsp_exp), xsp);
            failed = 1'b1;
        end

    a_bc: assert property (@(posedge clk) disable iff (rst)
        cen && dec_bc && src == {2'b00, rfp, 4'h4} && !reg_inc && !reg_dec && !rfp_we
        && !inc_rfp && !dec_rfp && !idx_en && (size == SZ_NONE || flag_only)
        |=> src != $past(src) || src_out[15:0] == $past(src_out[15:0]) - 16'd1)
        else begin
            $error("FAILED bc_dec expected %h actual %h", $past(src_out[15:0]) - 16'd1,
                   src_out[15:0]);
            failed = 1'b1;
        end

    a_unity: assert property (@(posedge clk) disable iff (rst)
        cen && !idx_en && src == {2'b00, rfp, 4'h4}
        |=> bc_unity == ($past(src_out[15:0]) == 16'd1))
        else begin
            $error("FAILED bc_unity expected %b actual %b", $past(src_out[15:0]) == 16'd1,
                   bc_unity);
            failed = 1'b1;
        end

    a_alu: assert property (@(posedge clk) disable iff (rst) 1'b1 |-> alu_dout == alu_exp[31:0])
        else begin
            $error("FAILED alu expected %h actual %h", alu_exp[31:0], alu_dout);
            failed = 1'b1;
        end

    a_sr: assert property (@(posedge clk) disable iff (rst)
        cen && alu_op != ALU_PASS && !data_sel |=> sr == $past(sr_exp))
        else begin
            $error("FAILED sr expected %h actual %h", $past(sr_exp), sr);
            failed = 1'b1;
        end

    // src must point at the long that holds the dumped byte
    a_dump: assert property (@(posedge clk) disable iff (rst)
        !idx_en && (dmp_addr < DUMP_PTR_BASE ? src == {2'b00, dmp_addr[5:2], 2'b00}
        : dmp_addr < DUMP_SR_BASE ? src == {4'h8, dmp_addr[3:2], 2'b00} : 1'b1)
        |=> dmp_din == $past(dump_exp))
        else begin
            $error("FAILED dump expected %h actual %h", $past(dump_exp), dmp_din);
            failed = 1'b1;
        end

endmodule

bind regs_top regs_properties u_props (.*);

//--- tb_regs.sv
// testbench for the register file top level
// clock, reset, directed and random stimulus, timeout
`timescale 1ns/100ps

module tb_regs;
    import cpu900_pkg::*;

    logic        clk = 1'b0;
    logic        rst, cen, inc_rfp, dec_rfp, rfp_we, dec_bc, reg_inc, reg_dec, dec_xde, dec_xix;
    logic        idx_en, data_sel, flag_only, bc_unity;
    logic [1:0]  imm, rfp;
    logic [2:0]  inc_xsp, dec_xsp;
    step_t       step;
    alu_op_t     alu_op;
    wr_size_t    size;
    logic [7:0]  src, dst, idx_sel, idx_aux, dmp_addr, dmp_din;
    logic [31:0] ram_dout, src_out, aux_out, dst_out, xsp;
    logic [15:0] sr;
    integer      seed;
    integer      r;
    integer      cycles = 0;

    regs_top i_regs_top (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (i_regs_top.u_props.failed) begin
            $display("TEST FAIL");
            $fatal(1, "an assertion check failed");
        end else if (cycles >= 600) begin
            $display("TEST FAIL");
            $fatal(1, "timeout, stimulus did not finish within 600 cycles");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic idle_inputs();
        {cen, inc_rfp, dec_rfp, rfp_we, dec_bc, reg_inc, reg_dec} = 7'b1000000;
        {dec_xde, dec_xix, idx_en, data_sel, flag_only} = 5'd0;
        {imm, inc_xsp, dec_xsp} = 8'd0;
        {src, dst, idx_sel, idx_aux, dmp_addr} = 40'd0;
        ram_dout = 32'd0;
        step     = STEP_1;
        alu_op   = ALU_PASS;
        size     = SZ_NONE;
    endtask

    // write ram data to code, then read it back on src and on the aux port
    task automatic write_code(logic [7:0] code, wr_size_t sz, logic fo);
        dst       = code;
        data_sel  = 1'b1;
        ram_dout  = $random(seed);
        size      = sz;
        flag_only = fo;
        next_cycle();
        idle_inputs();
        src     = code;
        idx_sel = code | 8'h04; // aux drops bit 2 again
        next_cycle();
    endtask

    initial begin
        seed = 39758;
        idle_inputs();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #5 rst = 1'b0;
        repeat (24) begin
            r = $random(seed);
            write_code(r[0] ? {4'h8, r[3:2], 2'b00} : r[1] ? {CUR_BANK, r[3:2], 2'b00}
                       : {2'b00, r[5:4], r[3:2], 2'b00},
                       r[9:8] == 0 ? SZ_BYTE : r[9:8] == 1 ? SZ_WORD : SZ_LONG, r[12:10] == 0);
        end
        // random data in the first two longs of every bank
        for (int k = 0; k < 4; k++) begin
            write_code({2'b00, 2'(k), 4'h0}, SZ_LONG, 1'b0);
            write_code({2'b00, 2'(k), 4'h4}, SZ_LONG, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            rfp_we = 1'b1;
            imm    = 2'(k);
            next_cycle();
            idle_inputs();
            {src, dst} = {CUR_BANK, 4'h4, 2'b00, 2'(k), 4'h4};
            next_cycle();
            {src, dst} = {PREV_BANK, 4'h0, 2'b00, 2'(k - 1), 4'h0};
            next_cycle();
            src = {ZERO_PAGE, 4'h4};
            next_cycle();
        end
        repeat (24) begin
            r = $random(seed);
            {cen, inc_rfp, dec_rfp, rfp_we, imm} = r[5:0];
            next_cycle();
        end
        idle_inputs();
        repeat (16) begin
            r   = $random(seed);
            src = {2'b00, r[1:0], r[3:2], 2'b00};
            step = step_t'(r[5:4]);
            if (r[13])
                {reg_inc, reg_dec} = {r[6], !r[6]};
            else
                {inc_xsp, dec_xsp} = r[12:7];
            next_cycle();
            {reg_inc, reg_dec, inc_xsp, dec_xsp} = 8'd0;
            next_cycle();
        end
        data_sel = 1'b1;
        dst      = {CUR_BANK, 4'h4};
        size     = SZ_WORD;
        ram_dout = 32'd3;
        next_cycle();
        idle_inputs();
        src    = {2'b00, rfp, 4'h4};
        dec_bc = 1'b1;
        repeat (4) next_cycle();
        idle_inputs();
        for (int i = 0; i < 96; i++) begin
            r         = $random(seed);
            alu_op    = alu_op_t'(i % 6);
            size      = r[9:8] == 0 ? SZ_BYTE : r[9:8] == 1 ? SZ_WORD : SZ_LONG;
            flag_only = r[0];
            dst       = {2'b00, r[7:4], 2'b00};
            dmp_addr  = 8'(i);
            src       = i < 64 ? {2'b00, 4'(i / 4), 2'b00}
                        : i < 80 ? {4'h8, 2'(i / 4), 2'b00} : {2'b00, r[13:10], 2'b00};
            next_cycle();
        end
        idle_inputs();
        repeat (2) next_cycle();
        if (i_regs_top.u_props.failed) begin
            $display("TEST FAIL");
            $fatal(1, "an assertion check failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- all.f
cpu900_pkg.sv
reg_code_dec.sv
reg_bank.sv
alu_flags.sv
reg_dump.sv
regs_top.sv
regs_properties.sv
tb_regs.sv
